/* id_params.svh */
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// datapath widths
`define ID_INST_W      32
`define ID_DATA_W      32
`define ID_REG_ADDR_W  5
`define ID_SHAMT_W     5
`define ID_IMM_W       16

// primary opcodes, inst[31:26]
`define OP_SPECIAL     6'b000000
`define OP_ANDI        6'b001100
`define OP_ORI         6'b001101
`define OP_XORI        6'b001110
`define OP_LUI         6'b001111
`define OP_PREF        6'b110011

// special function codes, inst[5:0]
`define FUNC_SLL       6'b000000   // nop and ssnop are sll encodings
`define FUNC_SRL       6'b000010
`define FUNC_SRA       6'b000011
`define FUNC_SLLV      6'b000100
`define FUNC_SRLV      6'b000110
`define FUNC_SRAV      6'b000111
`define FUNC_MOVZ      6'b001010
`define FUNC_MOVN      6'b001011
`define FUNC_SYNC      6'b001111
`define FUNC_MFHI      6'b010000
`define FUNC_MTHI      6'b010001
`define FUNC_MFLO      6'b010010
`define FUNC_MTLO      6'b010011
`define FUNC_AND       6'b100100
`define FUNC_OR        6'b100101
`define FUNC_XOR       6'b100110
`define FUNC_NOR       6'b100111

`endif

/* id_pkg.sv */
`include "id_params.svh"

package id_pkg;

    typedef logic [`ID_DATA_W-1:0]     data_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ID_INST_W-1:0]     inst_t;

    // result class, picks the execute-stage result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOV   = 3'b011
    } alusel_e;

    // operation within a class
    typedef enum logic [7:0] {
        OP_NOP  = 8'b0000_0000,
        OP_SRL  = 8'b0000_0010,
        OP_SRA  = 8'b0000_0011,
        OP_MOVZ = 8'b0000_1010,
        OP_MOVN = 8'b0000_1011,
        OP_MFHI = 8'b0001_0000,
        OP_MTHI = 8'b0001_0001,
        OP_MFLO = 8'b0001_0010,
        OP_MTLO = 8'b0001_0011,
        OP_AND  = 8'b0010_0100,
        OP_OR   = 8'b0010_0101,
        OP_XOR  = 8'b0010_0110,
        OP_NOR  = 8'b0010_0111,
        OP_SLL  = 8'b0111_1100
    } aluop_e;

    // decode result handed to execute
    typedef struct packed {
        alusel_e   alusel;
        aluop_e    aluop;
        data_t     reg1_data;
        data_t     reg2_data;
        reg_addr_t waddr;
        logic      wreg;
        logic      invalid;
    } id_ex_t;

endpackage

/* id_decoder.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_decoder (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::alusel_e   alusel_o,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::data_t     imm_o,
    output logic              use_imm_o,
    output logic              cond_move_o,
    output logic              move_if_zero_o,
    output logic              invalid_o
);

    logic [5:0]              opcode;
    logic [5:0]              func;
    id_pkg::reg_addr_t       rs;
    id_pkg::reg_addr_t       rt;
    id_pkg::reg_addr_t       rd;
    logic [`ID_SHAMT_W-1:0]  shamt;
    logic [`ID_IMM_W-1:0]    imm16;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign func   = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    // operation for a special-opcode function field
    function automatic id_pkg::aluop_e special_op(input logic [5:0] f);
        case (f)
            `FUNC_AND:               return id_pkg::OP_AND;
            `FUNC_OR:                return id_pkg::OP_OR;
            `FUNC_XOR:               return id_pkg::OP_XOR;
            `FUNC_NOR:               return id_pkg::OP_NOR;
            `FUNC_SLL, `FUNC_SLLV:   return id_pkg::OP_SLL;
            `FUNC_SRL, `FUNC_SRLV:   return id_pkg::OP_SRL;
            `FUNC_SRA, `FUNC_SRAV:   return id_pkg::OP_SRA;
            `FUNC_MOVN:              return id_pkg::OP_MOVN;
            `FUNC_MOVZ:              return id_pkg::OP_MOVZ;
            `FUNC_MFHI:              return id_pkg::OP_MFHI;
            `FUNC_MFLO:              return id_pkg::OP_MFLO;
            `FUNC_MTHI:              return id_pkg::OP_MTHI;
            `FUNC_MTLO:              return id_pkg::OP_MTLO;
            default:                 return id_pkg::OP_NOP;
        endcase
    endfunction

    // i-type logic ops, lui is an or against r0
    function automatic id_pkg::aluop_e imm_op(input logic [5:0] op);
        case (op)
            `OP_ANDI: return id_pkg::OP_AND;
            `OP_XORI: return id_pkg::OP_XOR;
            default:  return id_pkg::OP_OR;
        endcase
    endfunction

    always_comb begin
        // everything off unless an encoding claims it
        alusel_o       = id_pkg::SEL_NOP;
        aluop_o        = id_pkg::OP_NOP;
        waddr_o        = '0;
        wreg_o         = 1'b0;
        reg1_read_o    = 1'b0;
        reg1_addr_o    = '0;
        reg2_read_o    = 1'b0;
        reg2_addr_o    = '0;
        imm_o          = '0;
        use_imm_o      = 1'b0;
        cond_move_o    = 1'b0;
        move_if_zero_o = 1'b0;
        invalid_o      = 1'b0;

        case (opcode)
            `OP_SPECIAL: begin
                if (func == `FUNC_SLL || func == `FUNC_SRL || func == `FUNC_SRA) begin
                    // immediate shifts, all-zero word is the nop
                    alusel_o    = id_pkg::SEL_SHIFT;
                    aluop_o     = special_op(func);
                    waddr_o     = rd;
                    wreg_o      = 1'b1;
                    reg1_read_o = 1'b1;
                    reg1_addr_o = rt;              // value to shift
                    use_imm_o   = 1'b1;
                    imm_o       = {{(`ID_DATA_W-`ID_SHAMT_W){1'b0}}, shamt};
                end else if (shamt == '0) begin
                    case (func)
                        `FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR,
                        `FUNC_MOVN, `FUNC_MOVZ: begin
                            alusel_o       = (func == `FUNC_MOVN || func == `FUNC_MOVZ) ?
                                             id_pkg::SEL_MOV : id_pkg::SEL_LOGIC;
                            aluop_o        = special_op(func);
                            waddr_o        = rd;
                            wreg_o         = 1'b1;  // movn/movz resolved downstream
                            reg1_read_o    = 1'b1;
                            reg1_addr_o    = rs;
                            reg2_read_o    = 1'b1;
                            reg2_addr_o    = rt;
                            cond_move_o    = (func == `FUNC_MOVN || func == `FUNC_MOVZ);
                            move_if_zero_o = (func == `FUNC_MOVZ);
                        end
                        `FUNC_SLLV, `FUNC_SRLV, `FUNC_SRAV: begin
                            alusel_o    = id_pkg::SEL_SHIFT;
                            aluop_o     = special_op(func);
                            waddr_o     = rd;
                            wreg_o      = 1'b1;
                            reg1_read_o = 1'b1;
                            reg1_addr_o = rt;      // value
                            reg2_read_o = 1'b1;
                            reg2_addr_o = rs;      // amount
                        end
                        `FUNC_MFHI, `FUNC_MFLO: begin
                            alusel_o = id_pkg::SEL_MOV;
                            aluop_o  = special_op(func);
                            waddr_o  = rd;
                            wreg_o   = 1'b1;
                        end
                        `FUNC_MTHI, `FUNC_MTLO: begin
                            aluop_o     = special_op(func);
                            reg1_read_o = 1'b1;
                            reg1_addr_o = rs;
                        end
                        `FUNC_SYNC: ;             // no-op, nothing to request
                        default:    invalid_o = 1'b1;
                    endcase
                end else begin
                    invalid_o = 1'b1;              // register forms need shamt of zero
                end
            end
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                alusel_o    = id_pkg::SEL_LOGIC;
                aluop_o     = imm_op(opcode);
                waddr_o     = rt;
                wreg_o      = 1'b1;
                reg1_read_o = 1'b1;
                reg1_addr_o = rs;
                use_imm_o   = 1'b1;
                if (opcode == `OP_LUI) begin
                    imm_o = {imm16, {(`ID_DATA_W-`ID_IMM_W){1'b0}}};
                end else begin
                    imm_o = {{(`ID_DATA_W-`ID_IMM_W){1'b0}}, imm16};  // zero extend
                end
            end
            `OP_PREF: ;                            // treated as a no-op
            default: invalid_o = 1'b1;
        endcase
    end

    // unknown encodings must not touch the register file
    invalid_quiet: assert property (
        @(inst_i) invalid_o |-> !(wreg_o || reg1_read_o || reg2_read_o)
    ) else $error("invalid encoding requests a read or write");

endmodule

/* id_operand_sel.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_operand_sel (
    input  logic              reg1_read_i,
    input  logic              reg2_read_i,
    input  logic              use_imm_i,
    input  logic              cond_move_i,
    input  logic              move_if_zero_i,
    input  logic              wreg_i,
    input  id_pkg::data_t     reg1_data_i,
    input  id_pkg::data_t     reg2_data_i,
    input  id_pkg::data_t     imm_i,
    input  id_pkg::alusel_e   alusel_i,
    input  id_pkg::aluop_e    aluop_i,
    input  id_pkg::reg_addr_t waddr_i,
    input  logic              invalid_i,
    output id_pkg::id_ex_t    payload_o
);

    id_pkg::data_t op1;
    id_pkg::data_t op2;
    logic          move_taken;
    logic          wreg;

    assign op1 = reg1_read_i ? reg1_data_i : '0;

    always_comb begin
        if (reg2_read_i) begin
            op2 = reg2_data_i;
        end else if (use_imm_i) begin
            op2 = imm_i;                           // extended imm or shift amount
        end else begin
            op2 = '0;
        end
    end

    // movn writes on nonzero rt, movz on zero rt
    assign move_taken = move_if_zero_i ? (reg2_data_i == '0) : (reg2_data_i != '0);
    assign wreg       = wreg_i && (!cond_move_i || move_taken);

    assign payload_o.alusel    = alusel_i;
    assign payload_o.aluop     = aluop_i;
    assign payload_o.reg1_data = op1;
    assign payload_o.reg2_data = op2;
    assign payload_o.waddr     = waddr_i;
    assign payload_o.wreg      = wreg;
    assign payload_o.invalid   = invalid_i;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_ex_reg #(
    parameter type payload_t = id_pkg::id_ex_t
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // free slot, or the held item leaves this edge
    assign in_ready_o = !valid_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            data_q  <= in_data_i;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;                       // drained with nothing behind it
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // stalled output must not change under execute
    held_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
    ) else $error("output changed while stalled");

endmodule

/* id_stage.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage (
    input  logic              clk,
    input  logic              reset_i,
    // fetch side
    input  logic              inst_valid_i,
    output logic              inst_ready_o,
    input  id_pkg::inst_t     inst_i,
    // register file read ports
    output logic              reg1_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    input  id_pkg::data_t     reg1_data_i,
    input  id_pkg::data_t     reg2_data_i,
    // execute side
    output logic              ex_valid_o,
    input  logic              ex_ready_i,
    output id_pkg::alusel_e   alusel_o,
    output id_pkg::aluop_e    aluop_o,
    output id_pkg::data_t     reg1_data_o,
    output id_pkg::data_t     reg2_data_o,
    output id_pkg::reg_addr_t waddr_o,
    output logic              wreg_o,
    output logic              invalid_o
);

    id_pkg::alusel_e   dec_alusel;
    id_pkg::aluop_e    dec_aluop;
    id_pkg::reg_addr_t dec_waddr;
    logic              dec_wreg;
    id_pkg::data_t     dec_imm;
    logic              dec_use_imm;
    logic              dec_cond_move;
    logic              dec_move_if_zero;
    logic              dec_invalid;
    id_pkg::id_ex_t    payload_d;
    id_pkg::id_ex_t    payload_q;

    id_decoder u_decoder (
        .inst_i         (inst_i),
        .alusel_o       (dec_alusel),
        .aluop_o        (dec_aluop),
        .waddr_o        (dec_waddr),
        .wreg_o         (dec_wreg),
        .reg1_read_o    (reg1_read_o),
        .reg1_addr_o    (reg1_addr_o),
        .reg2_read_o    (reg2_read_o),
        .reg2_addr_o    (reg2_addr_o),
        .imm_o          (dec_imm),
        .use_imm_o      (dec_use_imm),
        .cond_move_o    (dec_cond_move),
        .move_if_zero_o (dec_move_if_zero),
        .invalid_o      (dec_invalid)
    );

    id_operand_sel u_operand_sel (
        .reg1_read_i    (reg1_read_o),
        .reg2_read_i    (reg2_read_o),
        .use_imm_i      (dec_use_imm),
        .cond_move_i    (dec_cond_move),
        .move_if_zero_i (dec_move_if_zero),
        .wreg_i         (dec_wreg),
        .reg1_data_i    (reg1_data_i),
        .reg2_data_i    (reg2_data_i),
        .imm_i          (dec_imm),
        .alusel_i       (dec_alusel),
        .aluop_i        (dec_aluop),
        .waddr_i        (dec_waddr),
        .invalid_i      (dec_invalid),
        .payload_o      (payload_d)
    );

    id_ex_reg #(
        .payload_t (id_pkg::id_ex_t)
    ) u_ex_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (inst_valid_i),
        .in_ready_o  (inst_ready_o),
        .in_data_i   (payload_d),
        .out_valid_o (ex_valid_o),
        .out_ready_i (ex_ready_i),
        .out_data_o  (payload_q)
    );

    // held payload out as loose fields
    assign alusel_o    = payload_q.alusel;
    assign aluop_o     = payload_q.aluop;
    assign reg1_data_o = payload_q.reg1_data;
    assign reg2_data_o = payload_q.reg2_data;
    assign waddr_o     = payload_q.waddr;
    assign wreg_o      = payload_q.wreg;
    assign invalid_o   = payload_q.invalid;

    // an invalid result reaching execute carries no write and no operands
    invalid_inert: assert property (
        @(posedge clk) disable iff (reset_i)
        ex_valid_o && invalid_o |-> !wreg_o && reg1_data_o == '0 && reg2_data_o == '0
    ) else $error("invalid result carries a write or operand data");

endmodule

/* tb_id_stage.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module tb_id_stage;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    // rough cycle budget per test, used by the watchdog
    localparam int run_cycles   = reset_cycles + 4 * 16 + 6 * 4 + 4 * 4 + 8 * 4 + 20 + 20;
    localparam int margin_ns    = 2000;

    logic                  clk;
    logic                  reset_i;
    logic                  inst_valid_i;
    logic                  inst_ready_o;
    id_pkg::inst_t         inst_i;
    logic                  reg1_read_o;
    id_pkg::reg_addr_t     reg1_addr_o;
    logic                  reg2_read_o;
    id_pkg::reg_addr_t     reg2_addr_o;
    id_pkg::data_t         reg1_data_i;
    id_pkg::data_t         reg2_data_i;
    logic                  ex_valid_o;
    logic                  ex_ready_i;
    id_pkg::alusel_e       alusel_o;
    id_pkg::aluop_e        aluop_o;
    id_pkg::data_t         reg1_data_o;
    id_pkg::data_t         reg2_data_o;
    id_pkg::reg_addr_t     waddr_o;
    logic                  wreg_o;
    logic                  invalid_o;

    id_pkg::data_t         rf [32];    // register file model
    logic [31:0]           lcg_state = 32'h7593_9d81;
    int                    errors = 0;
    int                    checks = 0;

    id_stage u_id_stage (.*);

    // combinational read ports, disabled reads come in on address 0
    assign reg1_data_i = rf[reg1_addr_o];
    assign reg2_data_i = rf[reg2_addr_o];

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic id_pkg::inst_t r_inst(input int rs, rt, rd, shamt, input logic [5:0] f);
        return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], f};
    endfunction

    function automatic id_pkg::inst_t i_inst(input logic [5:0] op, input int rs, rt,
                                             input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // expected payload and read requests straight from the decode rules
    task automatic ref_decode(input id_pkg::inst_t inst, output id_pkg::id_ex_t e,
                              output logic rd1, output id_pkg::reg_addr_t a1,
                              output logic rd2, output id_pkg::reg_addr_t a2);
        logic [5:0]  op;
        logic [5:0]  f;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        sa = inst[10:6];
        f  = inst[5:0];
        e  = '0;
        rd1 = 1'b0;
        a1  = '0;
        rd2 = 1'b0;
        a2  = '0;
        if (op == `OP_SPECIAL && f inside {`FUNC_SLL, `FUNC_SRL, `FUNC_SRA}) begin
            e.alusel    = id_pkg::SEL_SHIFT;
            e.aluop     = (f == `FUNC_SLL) ? id_pkg::OP_SLL :
                          (f == `FUNC_SRL) ? id_pkg::OP_SRL : id_pkg::OP_SRA;
            e.reg1_data = rf[rt];
            e.reg2_data = {27'd0, sa};
            e.waddr     = rd;
            e.wreg      = 1'b1;
            rd1         = 1'b1;
            a1          = rt;
        end else if (op == `OP_SPECIAL && sa == 5'd0) begin
            case (f)
                `FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR: begin
                    e.alusel = id_pkg::SEL_LOGIC;
                    e.aluop  = (f == `FUNC_AND) ? id_pkg::OP_AND : (f == `FUNC_OR) ?
                               id_pkg::OP_OR : (f == `FUNC_XOR) ? id_pkg::OP_XOR : id_pkg::OP_NOR;
                    e.reg1_data = rf[rs];
                    e.reg2_data = rf[rt];
                    e.waddr     = rd;
                    e.wreg      = 1'b1;
                    rd1         = 1'b1;
                    a1          = rs;
                    rd2         = 1'b1;
                    a2          = rt;
                end
                `FUNC_SLLV, `FUNC_SRLV, `FUNC_SRAV: begin
                    e.alusel    = id_pkg::SEL_SHIFT;
                    e.aluop     = (f == `FUNC_SLLV) ? id_pkg::OP_SLL :
                                  (f == `FUNC_SRLV) ? id_pkg::OP_SRL : id_pkg::OP_SRA;
                    e.reg1_data = rf[rt];      // value
                    e.reg2_data = rf[rs];      // amount
                    e.waddr     = rd;
                    e.wreg      = 1'b1;
                    rd1         = 1'b1;
                    a1          = rt;
                    rd2         = 1'b1;
                    a2          = rs;
                end
                `FUNC_MOVN, `FUNC_MOVZ: begin
                    e.alusel    = id_pkg::SEL_MOV;
                    e.aluop     = (f == `FUNC_MOVN) ? id_pkg::OP_MOVN : id_pkg::OP_MOVZ;
                    e.reg1_data = rf[rs];
                    e.reg2_data = rf[rt];
                    e.waddr     = rd;
                    e.wreg      = (f == `FUNC_MOVN) ? (rf[rt] != 0) : (rf[rt] == 0);
                    rd1         = 1'b1;
                    a1          = rs;
                    rd2         = 1'b1;
                    a2          = rt;
                end
                `FUNC_MFHI, `FUNC_MFLO: begin
                    e.alusel = id_pkg::SEL_MOV;
                    e.aluop  = (f == `FUNC_MFHI) ? id_pkg::OP_MFHI : id_pkg::OP_MFLO;
                    e.waddr  = rd;
                    e.wreg   = 1'b1;
                end
                `FUNC_MTHI, `FUNC_MTLO: begin
                    e.aluop     = (f == `FUNC_MTHI) ? id_pkg::OP_MTHI : id_pkg::OP_MTLO;
                    e.reg1_data = rf[rs];
                    rd1         = 1'b1;
                    a1          = rs;
                end
                `FUNC_SYNC: ;
                default: e.invalid = 1'b1;
            endcase
        end else if (op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI}) begin
            e.alusel    = id_pkg::SEL_LOGIC;
            e.aluop     = (op == `OP_ANDI) ? id_pkg::OP_AND :
                          (op == `OP_XORI) ? id_pkg::OP_XOR : id_pkg::OP_OR;
            e.reg1_data = rf[rs];
            e.reg2_data = (op == `OP_LUI) ? {inst[15:0], 16'd0} : {16'd0, inst[15:0]};
            e.waddr     = rt;
            e.wreg      = 1'b1;
            rd1         = 1'b1;
            a1          = rs;
        end else if (op != `OP_PREF) begin
            e.invalid = 1'b1;
        end
    endtask

    task automatic check_data(input string name, input id_pkg::data_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input id_pkg::reg_addr_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input id_pkg::alusel_e got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_op(input string name, input id_pkg::aluop_e got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_result(input id_pkg::id_ex_t e);
        check_bit("ex_valid_o", ex_valid_o, 1'b1);
        check_sel("alusel_o", alusel_o, e.alusel);
        check_op("aluop_o", aluop_o, e.aluop);
        check_data("reg1_data_o", reg1_data_o, e.reg1_data);
        check_data("reg2_data_o", reg2_data_o, e.reg2_data);
        check_addr("waddr_o", waddr_o, e.waddr);
        check_bit("wreg_o", wreg_o, e.wreg);
        check_bit("invalid_o", invalid_o, e.invalid);
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic send_check(input id_pkg::inst_t inst);
        id_pkg::id_ex_t    e;
        logic              rd1;
        logic              rd2;
        id_pkg::reg_addr_t a1;
        id_pkg::reg_addr_t a2;
        int                wait_cnt;
        logic              accepted;
        ref_decode(inst, e, rd1, a1, rd2, a2);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        accepted     = 1'b0;
        wait_cnt     = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready_o;
            wait_cnt++;
            if (wait_cnt > 21) begin
                errors++;
                $display("inst_ready_o never rose for instruction %h", inst);
                accepted = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        inst_valid_i = 1'b0;
        @(negedge clk);
        check_result(e);
        // inst_i still holds the instruction, so the read ports still decode it
        check_bit("reg1_read_o", reg1_read_o, rd1);
        check_addr("reg1_addr_o", reg1_addr_o, a1);
        check_bit("reg2_read_o", reg2_read_o, rd2);
        check_addr("reg2_addr_o", reg2_addr_o, a2);
        @(posedge clk);
        #2;
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "mismatches found");
    endtask

    task automatic test_logic();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            send_check(r_inst(lcg_next() % 32, lcg_next() % 32, lcg_next() % 32, 0,
                              (i % 4 == 0) ? `FUNC_AND : (i % 4 == 1) ? `FUNC_OR :
                              (i % 4 == 2) ? `FUNC_XOR : `FUNC_NOR));
        end
        report("register logic", e0);
    endtask

    task automatic test_shifts();
        int e0;
        e0 = errors;
        send_check(r_inst(0, 7, 3, 5, `FUNC_SLL));
        send_check(r_inst(0, 9, 4, 31, `FUNC_SRL));
        send_check(r_inst(0, 11, 6, 1, `FUNC_SRA));
        send_check(r_inst(2, 7, 3, 0, `FUNC_SLLV));
        send_check(r_inst(13, 9, 4, 0, `FUNC_SRLV));
        send_check(r_inst(21, 11, 6, 0, `FUNC_SRAV));
        send_check(32'h0000_0000);         // nop
        report("shifts", e0);
    endtask

    task automatic test_immediates();
        int e0;
        e0 = errors;
        send_check(i_inst(`OP_ANDI, 3, 8, 16'hf00f));
        send_check(i_inst(`OP_ORI, 12, 17, 16'h8421));
        send_check(i_inst(`OP_XORI, 30, 1, 16'hffff));
        send_check(i_inst(`OP_LUI, 0, 22, 16'hbeef));
        report("immediates", e0);
    endtask

    task automatic test_moves();
        int e0;
        e0 = errors;
        send_check(r_inst(4, 5, 10, 0, `FUNC_MOVN));    // rt nonzero
        send_check(r_inst(4, 0, 10, 0, `FUNC_MOVN));    // rt zero
        send_check(r_inst(6, 5, 11, 0, `FUNC_MOVZ));
        send_check(r_inst(6, 0, 11, 0, `FUNC_MOVZ));
        send_check(r_inst(0, 0, 14, 0, `FUNC_MFHI));
        send_check(r_inst(0, 0, 15, 0, `FUNC_MFLO));
        send_check(r_inst(18, 0, 0, 0, `FUNC_MTHI));
        send_check(r_inst(19, 0, 0, 0, `FUNC_MTLO));
        report("moves", e0);
    endtask

    task automatic test_backpressure();
        id_pkg::inst_t     insts [3];
        id_pkg::id_ex_t    exp_q [$];
        id_pkg::id_ex_t    e;
        logic              rd1;
        logic              rd2;
        id_pkg::reg_addr_t a1;
        id_pkg::reg_addr_t a2;
        int                e0;
        int                idx;
        int                cycle;
        logic              acc;
        e0       = errors;
        insts[0] = r_inst(1, 2, 3, 0, `FUNC_AND);
        insts[1] = i_inst(`OP_ORI, 4, 5, 16'h1234);
        insts[2] = r_inst(0, 6, 7, 9, `FUNC_SRA);
        for (int i = 0; i < 3; i++) begin
            ref_decode(insts[i], e, rd1, a1, rd2, a2);
            exp_q.push_back(e);
        end
        idx          = 0;
        cycle        = 0;
        ex_ready_i   = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = insts[0];
        while (exp_q.size() > 0 && cycle < 30) begin
            @(negedge clk);
            if (cycle >= 1 && cycle <= 4) begin     // stalled, first result held
                check_bit("inst_ready_o", inst_ready_o, 1'b0);
                check_result(exp_q[0]);
            end
            if (ex_valid_o && ex_ready_i) begin
                check_result(exp_q.pop_front());
            end
            acc = inst_valid_i && inst_ready_o;
            @(posedge clk);
            #2;
            if (acc) begin
                idx++;
                inst_valid_i = (idx < 3);
                if (idx < 3) inst_i = insts[idx];
            end
            ex_ready_i = (cycle >= 4);
            cycle++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("%0d results lost under back-pressure", exp_q.size());
        end
        inst_valid_i = 1'b0;
        ex_ready_i   = 1'b1;
        report("back-pressure", e0);
    endtask

    task automatic test_reset_invalid();
        int e0;
        e0 = errors;
        ex_ready_i = 1'b0;
        send_check(r_inst(1, 2, 3, 0, `FUNC_OR));       // leaves a held result
        reset_i = 1'b1;
        @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        check_bit("ex_valid_o", ex_valid_o, 1'b0);
        check_data("reg1_data_o", reg1_data_o, '0);
        check_bit("wreg_o", wreg_o, 1'b0);
        @(posedge clk);
        #2;
        ex_ready_i = 1'b1;
        send_check(i_inst(6'b111111, 5, 6, 16'h00ff)); // unknown opcode
        send_check(r_inst(0, 0, 0, 0, 6'b101010));     // unknown function
        send_check(r_inst(0, 0, 0, 0, `FUNC_SYNC));
        send_check(i_inst(`OP_PREF, 3, 4, 16'h0010));
        report("reset and invalid", e0);
    endtask

    initial begin
        #(run_cycles * clk_period + margin_ns);
        $display("watchdog expired, the run did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rf[0] = '0;
        for (int i = 1; i < 32; i++) rf[i] = lcg_next();
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        ex_ready_i   = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        check_bit("ex_valid_o", ex_valid_o, 1'b0);  // empty after reset
        @(posedge clk);
        #2;
        test_logic();
        test_shifts();
        test_immediates();
        test_moves();
        test_backpressure();
        test_reset_invalid();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_sel.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv
